/* rtl/credit_pkg.sv */
package credit_pkg;

	// router dimensions
	localparam int NUM_VC = 4; // vcs per port
	localparam int NUM_PORT = 5; // router ports
	localparam int NUM_PEER = NUM_PORT - 1; // every port except the own one
	localparam int NUM_OVC = NUM_VC * NUM_PORT; // all output vcs

	// one-hot vc select inside a port
	typedef logic [NUM_VC-1:0] vc_sel_t;

	// one-hot destination among the other ports
	typedef logic [NUM_PEER-1:0] peer_sel_t;

	// one bit per vc of the other ports, peer d at bits d*NUM_VC+v
	typedef logic [NUM_PEER*NUM_VC-1:0] peer_vc_t;

	// one bit per vc of the router, port o at bits o*NUM_VC+v
	typedef logic [NUM_OVC-1:0] ovc_vec_t;

	typedef vc_sel_t [NUM_OVC-1:0] ovc_num_vec_t; // ovc number per input vc
	typedef peer_sel_t [NUM_OVC-1:0] ivc_dest_vec_t; // destination per input vc
	typedef peer_sel_t [NUM_PORT-1:0] port_dest_vec_t; // destination per input port

	// reallocation policy of an output vc
	typedef enum logic {
		REALLOC_NONATOMIC, // free and not nearly full
		REALLOC_ATOMIC // free and drained
	} realloc_mode_e;

	// output port named by peer index d as seen from input port i
	function automatic int peer_port(int port, int peer);
		int result;
		result = (peer < port) ? peer : peer + 1;
		return result;
	endfunction

endpackage

/* rtl/inport_grant_decoder.sv */
module inport_grant_decoder
	import credit_pkg::*;
(
	input vc_sel_t flit_is_tail,
	input vc_sel_t [NUM_VC-1:0] assigned_ovc_num,
	input vc_sel_t [NUM_VC-1:0] spec_ovc_num,
	input peer_sel_t nonspec_granted_dest_port,
	input peer_sel_t spec_granted_dest_port,
	input vc_sel_t nonspec_first_granted_ivc,
	input vc_sel_t spec_first_granted_ivc,
	output peer_vc_t credit_decreased,
	output peer_vc_t ovc_released
);

	// and-or mux of the granted ivc's ovc number
	function automatic vc_sel_t pick_ovc(vc_sel_t sel, vc_sel_t [NUM_VC-1:0] nums);
		vc_sel_t result;
		result = '0;
		for (int v = 0; v < NUM_VC; v++) begin
			result |= nums[v] & {NUM_VC{sel[v]}};
		end
		return result;
	endfunction

	// place the ovc bits in the slot of the granted destination
	function automatic peer_vc_t spread(peer_sel_t dest, vc_sel_t ovc);
		peer_vc_t result;
		result = '0;
		for (int d = 0; d < NUM_PEER; d++) begin
			result[d*NUM_VC +: NUM_VC] = ovc & {NUM_VC{dest[d]}};
		end
		return result;
	endfunction

	vc_sel_t nonspec_ovc;
	vc_sel_t spec_ovc;
	peer_vc_t nonspec_dec;
	peer_vc_t spec_dec;
	logic nonspec_tail;

	assign nonspec_ovc = pick_ovc(nonspec_first_granted_ivc, assigned_ovc_num);
	assign spec_ovc = pick_ovc(spec_first_granted_ivc, spec_ovc_num); // speculative path

	assign nonspec_dec = spread(nonspec_granted_dest_port, nonspec_ovc);
	assign spec_dec = spread(spec_granted_dest_port, spec_ovc);

	assign nonspec_tail = |(flit_is_tail & nonspec_first_granted_ivc);

	// both paths consume a buffer slot downstream
	assign credit_decreased = nonspec_dec | spec_dec;

	// only a committed tail frees the ovc
	assign ovc_released = nonspec_tail ? nonspec_dec : '0;

	// the switch allocator grants at most one ivc per path and port
	always_comb begin
		a_nonspec_onehot : assert final (
			$isunknown(nonspec_first_granted_ivc) || $onehot0(nonspec_first_granted_ivc)
		) else begin
			$error("nonspec grant select not one-hot: %b", nonspec_first_granted_ivc);
		end
		a_spec_onehot : assert final (
			$isunknown(spec_first_granted_ivc) || $onehot0(spec_first_granted_ivc)
		) else begin
			$error("spec grant select not one-hot: %b", spec_first_granted_ivc);
		end
	end

endmodule

/* rtl/ovc_credit_tracker.sv */
module ovc_credit_tracker
	import credit_pkg::*;
#(
	parameter int BUF_DEPTH = 4,
	parameter realloc_mode_e REALLOC_MODE = REALLOC_NONATOMIC
)(
	input logic clk,
	input logic reset,
	input ovc_vec_t credit_in,
	input ovc_vec_t credit_decreased,
	input ovc_vec_t ovc_released,
	input ovc_vec_t ovc_allocated,
	output ovc_vec_t full,
	output ovc_vec_t nearly_full,
	output ovc_vec_t ovc_available
);

	localparam int CNT_W = $clog2(BUF_DEPTH);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(BUF_DEPTH - 1); // all slots free

	logic [NUM_OVC-1:0][CNT_W-1:0] credit_cnt;
	logic [NUM_OVC-1:0][CNT_W-1:0] credit_cnt_next;
	ovc_vec_t full_next;
	ovc_vec_t nearly_full_next;
	ovc_vec_t ovc_status; // 1 = allocated

	// one step per cycle at most, credit and decrement cancel
	always_comb begin
		for (int k = 0; k < NUM_OVC; k++) begin
			credit_cnt_next[k] = credit_cnt[k];
			if (credit_in[k] && !credit_decreased[k]) begin
				credit_cnt_next[k] = credit_cnt[k] + 1'b1;
			end else if (!credit_in[k] && credit_decreased[k]) begin
				credit_cnt_next[k] = credit_cnt[k] - 1'b1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < NUM_OVC; k++) begin
			full_next[k] = (credit_cnt_next[k] == '0);
			nearly_full_next[k] = (credit_cnt_next[k] <= CNT_W'(1)); // one slot or none
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			credit_cnt <= {NUM_OVC{CNT_MAX}};
			full <= '0;
			nearly_full <= '0;
			ovc_status <= '0;
		end else begin
			credit_cnt <= credit_cnt_next;
			full <= full_next;
			nearly_full <= nearly_full_next;
			ovc_status <= (ovc_status & ~ovc_released) | ovc_allocated; // allocate wins
		end
	end

	generate
		if (REALLOC_MODE == REALLOC_ATOMIC) begin : g_atomic
			ovc_vec_t empty;
			ovc_vec_t empty_next;

			always_comb begin
				for (int k = 0; k < NUM_OVC; k++) begin
					empty_next[k] = (credit_cnt_next[k] == CNT_MAX);
				end
			end

			always_ff @(posedge clk or posedge reset) begin
				if (reset) begin
					empty <= '0; // first set one cycle after reset
				end else begin
					empty <= empty_next;
				end
			end

			// wait until the downstream buffer has drained
			assign ovc_available = ~ovc_status & empty;
		end else begin : g_nonatomic
			assign ovc_available = ~(ovc_status | nearly_full);
		end
	endgenerate

	// protocol guards on what the router feeds in
	generate
		for (genvar k = 0; k < NUM_OVC; k++) begin : g_chk
			a_no_extra_credit : assert property (
				@(posedge clk) disable iff (reset)
				!(credit_in[k] && !credit_decreased[k] && credit_cnt[k] == CNT_MAX)
			) else begin
				$error("credit returned to drained ovc %0d", k);
			end

			a_no_send_to_full : assert property (
				@(posedge clk) disable iff (reset)
				!(credit_decreased[k] && credit_cnt[k] == '0)
			) else begin
				$error("flit sent to full ovc %0d", k);
			end
		end
	endgenerate

	a_alloc_release : assert property (
		@(posedge clk) disable iff (reset)
		(ovc_allocated & ovc_released) == '0
	) else begin
		$error("ovc allocated and released together: %h", ovc_allocated & ovc_released);
	end

	a_release_free : assert property (
		@(posedge clk) disable iff (reset)
		(ovc_released & ~ovc_status) == '0
	) else begin
		$error("release of a free ovc: %h", ovc_released & ~ovc_status);
	end

	a_alloc_busy : assert property (
		@(posedge clk) disable iff (reset)
		(ovc_allocated & ovc_status) == '0
	) else begin
		$error("allocation of a busy ovc: %h", ovc_allocated & ovc_status);
	end

endmodule

/* rtl/ivc_full_check.sv */
module ivc_full_check
	import credit_pkg::*;
(
	input logic clk,
	input logic reset,
	input vc_sel_t assigned_ovc_num,
	input peer_sel_t dest_port,
	input peer_vc_t full,
	input peer_vc_t nearly_full,
	input peer_vc_t credit_in,
	input logic ivc_sw_grant,
	input logic flit_is_tail,
	output logic assigned_ovc_not_full,
	output logic reset_ivc
);

	peer_vc_t full_masked;
	peer_vc_t nearly_full_masked;
	vc_sel_t full_port;
	vc_sel_t nearly_full_port;
	logic full_sel;
	logic nearly_full_sel;
	logic full_reg1;
	logic full_reg2;

	// a credit arriving now frees one slot
	assign full_masked = full & ~credit_in;
	assign nearly_full_masked = nearly_full & ~credit_in;

	// pick the destination port's slice
	always_comb begin
		full_port = '0;
		nearly_full_port = '0;
		for (int d = 0; d < NUM_PEER; d++) begin
			full_port |= full_masked[d*NUM_VC +: NUM_VC] & {NUM_VC{dest_port[d]}};
			nearly_full_port |= nearly_full_masked[d*NUM_VC +: NUM_VC] & {NUM_VC{dest_port[d]}};
		end
	end

	// then the assigned vc inside it
	assign full_sel = |(full_port & assigned_ovc_num);
	assign nearly_full_sel = |(nearly_full_port & assigned_ovc_num);

	// Nearly full only matters when this ivc sends the flit that
	// takes the last slot, so it is qualified by the switch grant.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			full_reg1 <= 1'b0;
			full_reg2 <= 1'b0;
		end else begin
			full_reg1 <= full_sel;
			full_reg2 <= nearly_full_sel & ivc_sw_grant;
		end
	end

	assign assigned_ovc_not_full = ~(full_reg1 | full_reg2);

	assign reset_ivc = flit_is_tail & ivc_sw_grant; // tail leaves the ivc

endmodule

/* rtl/credit_counter_top.sv */
module credit_counter_top
	import credit_pkg::*;
#(
	parameter int BUF_DEPTH = 4,
	parameter realloc_mode_e REALLOC_MODE = REALLOC_NONATOMIC
)(
	input logic clk,
	input logic reset,
	input ovc_vec_t ovc_allocated,
	input ovc_vec_t flit_is_tail,
	input ovc_num_vec_t assigned_ovc_num,
	input ovc_num_vec_t spec_ovc_num,
	input ivc_dest_vec_t dest_port,
	input port_dest_vec_t nonspec_granted_dest_port,
	input port_dest_vec_t spec_granted_dest_port,
	input ovc_vec_t nonspec_first_granted_ivc,
	input ovc_vec_t spec_first_granted_ivc,
	input ovc_vec_t credit_in,
	input ovc_vec_t ivc_sw_grant,
	output ovc_vec_t ovc_available,
	output ovc_vec_t assigned_ovc_not_full,
	output ovc_vec_t reset_ivc
);

	peer_vc_t port_decreased [NUM_PORT]; // per input port, peer order
	peer_vc_t port_released [NUM_PORT];
	peer_vc_t peer_full [NUM_PORT];
	peer_vc_t peer_nearly_full [NUM_PORT];
	peer_vc_t peer_credit_in [NUM_PORT];
	ovc_vec_t credit_decreased;
	ovc_vec_t ovc_released;
	ovc_vec_t full;
	ovc_vec_t nearly_full;

	generate
		for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
			inport_grant_decoder decoder_i (
				.flit_is_tail(flit_is_tail[p*NUM_VC +: NUM_VC]),
				.assigned_ovc_num(assigned_ovc_num[p*NUM_VC +: NUM_VC]),
				.spec_ovc_num(spec_ovc_num[p*NUM_VC +: NUM_VC]),
				.nonspec_granted_dest_port(nonspec_granted_dest_port[p]),
				.spec_granted_dest_port(spec_granted_dest_port[p]),
				.nonspec_first_granted_ivc(nonspec_first_granted_ivc[p*NUM_VC +: NUM_VC]),
				.spec_first_granted_ivc(spec_first_granted_ivc[p*NUM_VC +: NUM_VC]),
				.credit_decreased(port_decreased[p]),
				.ovc_released(port_released[p])
			);
		end
	endgenerate

	// OR the peer bits of every input port into router ovc order
	always_comb begin
		credit_decreased = '0;
		ovc_released = '0;
		for (int p = 0; p < NUM_PORT; p++) begin
			for (int d = 0; d < NUM_PEER; d++) begin
				credit_decreased[peer_port(p, d)*NUM_VC +: NUM_VC] |=
					port_decreased[p][d*NUM_VC +: NUM_VC];
				ovc_released[peer_port(p, d)*NUM_VC +: NUM_VC] |=
					port_released[p][d*NUM_VC +: NUM_VC];
			end
		end
	end

	ovc_credit_tracker #(
		.BUF_DEPTH(BUF_DEPTH),
		.REALLOC_MODE(REALLOC_MODE)
	) tracker_i (
		.clk(clk),
		.reset(reset),
		.credit_in(credit_in),
		.credit_decreased(credit_decreased),
		.ovc_released(ovc_released),
		.ovc_allocated(ovc_allocated),
		.full(full),
		.nearly_full(nearly_full),
		.ovc_available(ovc_available)
	);

	// drop each port's own slice, back into peer order
	always_comb begin
		for (int p = 0; p < NUM_PORT; p++) begin
			for (int d = 0; d < NUM_PEER; d++) begin
				peer_full[p][d*NUM_VC +: NUM_VC] = full[peer_port(p, d)*NUM_VC +: NUM_VC];
				peer_nearly_full[p][d*NUM_VC +: NUM_VC] =
					nearly_full[peer_port(p, d)*NUM_VC +: NUM_VC];
				peer_credit_in[p][d*NUM_VC +: NUM_VC] =
					credit_in[peer_port(p, d)*NUM_VC +: NUM_VC];
			end
		end
	end

	generate
		for (genvar i = 0; i < NUM_OVC; i++) begin : g_ivc
			ivc_full_check check_i (
				.clk(clk),
				.reset(reset),
				.assigned_ovc_num(assigned_ovc_num[i]),
				.dest_port(dest_port[i]),
				.full(peer_full[i/NUM_VC]),
				.nearly_full(peer_nearly_full[i/NUM_VC]),
				.credit_in(peer_credit_in[i/NUM_VC]),
				.ivc_sw_grant(ivc_sw_grant[i]),
				.flit_is_tail(flit_is_tail[i]),
				.assigned_ovc_not_full(assigned_ovc_not_full[i]),
				.reset_ivc(reset_ivc[i])
			);
		end
	endgenerate

endmodule

/* verif/credit_model.svh */
`ifndef CREDIT_MODEL_SVH
`define CREDIT_MODEL_SVH

localparam int CNT_MAX = BUF_DEPTH - 1; // all downstream slots free

int ref_cnt [NUM_OVC]; // credits per output vc
ovc_vec_t ref_status; // 1 = allocated
ovc_vec_t ref_full;
ovc_vec_t ref_nearly_full;
ovc_vec_t ref_empty;
ovc_vec_t ref_full_reg; // look-ahead register one per input vc
ovc_vec_t ref_nf_reg; // look-ahead register two per input vc
ovc_vec_t want_dec; // output vcs that get a flit this cycle
ovc_vec_t want_rel; // output vcs freed by a committed tail
int ivc_out_port [NUM_OVC]; // destination port number per input vc
int ivc_vc [NUM_OVC]; // assigned vc number per input vc
int ivc_spec_vc [NUM_OVC];
int ivc_tail [NUM_OVC]; // tail drawn per input vc
int ivc_sent [NUM_OVC]; // switch grant drawn per input vc

// slot of output port out_port in the peer vectors of input port port
function automatic int peer_index(int port, int out_port);
	if (out_port < port) begin
		return out_port;
	end
	return out_port - 1;
endfunction

function automatic int pick_other_port(int port);
	int o;
	do begin
		o = $urandom_range(0, NUM_PORT - 1);
	end while (o == port);
	return o;
endfunction

task automatic reset_model();
	for (int k = 0; k < NUM_OVC; k++) begin
		ref_cnt[k] = CNT_MAX;
	end
	ref_status = '0;
	ref_full = '0;
	ref_nearly_full = '0;
	ref_empty = '0; // first set one cycle after reset
	ref_full_reg = '0;
	ref_nf_reg = '0;
endtask

// random inputs that keep every counter and status transition legal
task automatic pick_stimulus();
	int p;
	int v;
	int o;
	int k;
	int go;
	want_dec = '0;
	want_rel = '0;
	for (int i = 0; i < NUM_OVC; i++) begin
		p = i / NUM_VC;
		o = pick_other_port(p);
		ivc_out_port[i] = o;
		ivc_vc[i] = $urandom_range(0, NUM_VC - 1);
		ivc_spec_vc[i] = $urandom_range(0, NUM_VC - 1);
		dest_port[i] = peer_sel_t'(1) << peer_index(p, o);
		assigned_ovc_num[i] = vc_sel_t'(1) << ivc_vc[i];
		spec_ovc_num[i] = vc_sel_t'(1) << ivc_spec_vc[i];
		ivc_tail[i] = $urandom_range(0, 1);
		ivc_sent[i] = $urandom_range(0, 1);
		flit_is_tail[i] = 1'(ivc_tail[i]);
		ivc_sw_grant[i] = 1'(ivc_sent[i]);
	end
	nonspec_first_granted_ivc = '0;
	spec_first_granted_ivc = '0;
	for (p = 0; p < NUM_PORT; p++) begin
		v = $urandom_range(0, NUM_VC - 1); // committed path
		o = pick_other_port(p);
		k = o * NUM_VC + ivc_vc[p * NUM_VC + v];
		go = $urandom_range(0, 1);
		nonspec_granted_dest_port[p] = peer_sel_t'(1) << peer_index(p, o);
		if (go == 1 && ref_cnt[k] > 0 && !want_dec[k]) begin
			nonspec_first_granted_ivc[p * NUM_VC + v] = 1'b1;
			want_dec[k] = 1'b1;
			ivc_tail[p * NUM_VC + v] = $urandom_range(0, 1) & int'(ref_status[k]);
			flit_is_tail[p * NUM_VC + v] = 1'(ivc_tail[p * NUM_VC + v]);
			want_rel[k] = flit_is_tail[p * NUM_VC + v];
		end
		v = $urandom_range(0, NUM_VC - 1); // speculative path, never releases
		o = pick_other_port(p);
		k = o * NUM_VC + ivc_spec_vc[p * NUM_VC + v];
		go = $urandom_range(0, 1);
		spec_granted_dest_port[p] = peer_sel_t'(1) << peer_index(p, o);
		if (go == 1 && ref_cnt[k] > 0 && !want_dec[k]) begin
			spec_first_granted_ivc[p * NUM_VC + v] = 1'b1;
			want_dec[k] = 1'b1;
		end
	end
	for (k = 0; k < NUM_OVC; k++) begin
		go = $urandom_range(0, 3);
		credit_in[k] = (ref_cnt[k] - int'(want_dec[k]) < CNT_MAX) && go == 0;
		go = $urandom_range(0, 7);
		ovc_allocated[k] = !ref_status[k] && go == 0; // released vcs are busy
	end
endtask

// one rising edge of the reference
task automatic update_model();
	int k;
	int nxt;
	for (int i = 0; i < NUM_OVC; i++) begin
		k = ivc_out_port[i] * NUM_VC + ivc_vc[i];
		ref_full_reg[i] = ref_full[k] & ~credit_in[k]; // flags from before the edge
		ref_nf_reg[i] = ref_nearly_full[k] & ~credit_in[k] & ivc_sw_grant[i];
	end
	for (int j = 0; j < NUM_OVC; j++) begin
		nxt = ref_cnt[j] + int'(credit_in[j]) - int'(want_dec[j]);
		ref_full[j] = (nxt == 0);
		ref_nearly_full[j] = (nxt <= 1);
		ref_empty[j] = (nxt == CNT_MAX);
		ref_cnt[j] = nxt;
	end
	ref_status = (ref_status & ~want_rel) | ovc_allocated;
endtask

function automatic ovc_vec_t expected_available();
	if (REALLOC_MODE == REALLOC_ATOMIC) begin
		return ~ref_status & ref_empty;
	end
	return ~(ref_status | ref_nearly_full);
endfunction

function automatic ovc_vec_t expected_not_full();
	return ~(ref_full_reg | ref_nf_reg);
endfunction

// an input vc is emptied when its tail flit wins the switch
function automatic ovc_vec_t expected_reset_ivc();
	ovc_vec_t result;
	for (int i = 0; i < NUM_OVC; i++) begin
		result[i] = (ivc_tail[i] != 0) && (ivc_sent[i] != 0);
	end
	return result;
endfunction

`endif

/* verif/tb_credit_counter.sv */
module tb_credit_counter
	import credit_pkg::*;
#(
	parameter int BUF_DEPTH = 4,
	parameter realloc_mode_e REALLOC_MODE = REALLOC_NONATOMIC
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED = 96288;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_CYCLES = 3000;
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3; // margin over the run

	logic clk;
	logic reset;
	ovc_vec_t ovc_allocated;
	ovc_vec_t flit_is_tail;
	ovc_num_vec_t assigned_ovc_num;
	ovc_num_vec_t spec_ovc_num;
	ivc_dest_vec_t dest_port;
	port_dest_vec_t nonspec_granted_dest_port;
	port_dest_vec_t spec_granted_dest_port;
	ovc_vec_t nonspec_first_granted_ivc;
	ovc_vec_t spec_first_granted_ivc;
	ovc_vec_t credit_in;
	ovc_vec_t ivc_sw_grant;
	ovc_vec_t ovc_available;
	ovc_vec_t assigned_ovc_not_full;
	ovc_vec_t reset_ivc;
	int cycle_count = 0;

	`include "credit_model.svh"

	credit_counter_top #(
		.BUF_DEPTH(BUF_DEPTH),
		.REALLOC_MODE(REALLOC_MODE)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.ovc_allocated(ovc_allocated),
		.flit_is_tail(flit_is_tail),
		.assigned_ovc_num(assigned_ovc_num),
		.spec_ovc_num(spec_ovc_num),
		.dest_port(dest_port),
		.nonspec_granted_dest_port(nonspec_granted_dest_port),
		.spec_granted_dest_port(spec_granted_dest_port),
		.nonspec_first_granted_ivc(nonspec_first_granted_ivc),
		.spec_first_granted_ivc(spec_first_granted_ivc),
		.credit_in(credit_in),
		.ivc_sw_grant(ivc_sw_grant),
		.ovc_available(ovc_available),
		.assigned_ovc_not_full(assigned_ovc_not_full),
		.reset_ivc(reset_ivc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at cycle %0d", cycle_count);
	endtask

	task automatic check_available(ovc_vec_t got, ovc_vec_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail ovc_available: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_not_full(ovc_vec_t got, ovc_vec_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail assigned_ovc_not_full: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_reset_ivc(ovc_vec_t got, ovc_vec_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail reset_ivc: got %h expected %h", got, exp));
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout: run still going after %0d cycles", cycle_count));
		end
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		ovc_allocated = '0;
		flit_is_tail = '0;
		assigned_ovc_num = '0;
		spec_ovc_num = '0;
		dest_port = '0;
		nonspec_granted_dest_port = '0;
		spec_granted_dest_port = '0;
		nonspec_first_granted_ivc = '0;
		spec_first_granted_ivc = '0;
		credit_in = '0;
		ivc_sw_grant = '0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_available(ovc_available, expected_available()); // state right after reset
		check_not_full(assigned_ovc_not_full, expected_not_full());
		for (int n = 0; n < NUM_CYCLES; n++) begin
			pick_stimulus(); // on the falling edge
			@(posedge clk);
			check_reset_ivc(reset_ivc, expected_reset_ivc());
			update_model();
			#1; // registers settled
			check_available(ovc_available, expected_available());
			check_not_full(assigned_ovc_not_full, expected_not_full());
			@(negedge clk);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* build.f */
+incdir+verif
rtl/credit_pkg.sv
rtl/inport_grant_decoder.sv
rtl/ovc_credit_tracker.sv
rtl/ivc_full_check.sv
rtl/credit_counter_top.sv
verif/tb_credit_counter.sv
